//--- conv_pkg.sv
package conv_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Image geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int IMG_W    = 16;
    localparam int COL_W    = 4;
    localparam int ROW_W    = 10;
    localparam int NUM_BUFS = 3;

    // Kernel is KERN_K x KERN_K, stride 1
    localparam int KERN_K   = 3;
    localparam int KERN_N   = KERN_K * KERN_K;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int PIX_W    = 8;
    localparam int WGT_W    = 8;
    // Zero-extended pixel (9 bits) times signed weight (8 bits)
    localparam int PROD_W   = PIX_W + 1 + WGT_W;
    localparam int ACC_W    = 20;
    localparam int SHIFT_W  = 5;
    localparam int PIX_MAX  = 255;

    typedef logic        [PIX_W-1:0]   pixel_t;
    typedef logic signed [WGT_W-1:0]   weight_t;
    typedef logic        [COL_W-1:0]   col_t;
    typedef logic        [ROW_W-1:0]   row_t;
    typedef logic signed [PROD_W-1:0]  prod_t;
    typedef logic signed [ACC_W-1:0]   acc_t;
    typedef logic        [SHIFT_W-1:0] shift_t;

    // Index 0 is top-left, then row by row
    typedef weight_t [KERN_N-1:0] kernel_t;
    typedef pixel_t  [KERN_N-1:0] win_t;

    // Index 0 holds the oldest row
    typedef pixel_t  [KERN_K-1:0] col3_t;

    localparam col_t LAST_COL = col_t'(IMG_W - 1);

endpackage

//--- pix_stream_if.sv
`timescale 1ns/1ps

// Valid/ready stream between datapath stages
interface pix_stream_if #(
    parameter type data_t = conv_pkg::pixel_t
);

    logic  valid;
    logic  ready;
    data_t data;
    // Final item of a frame
    logic  last;
    // Final item of a row
    logic  eol;

    modport source (
        output valid,
        output data,
        output last,
        output eol,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  last,
        input  eol,
        output ready
    );

endinterface

//--- conv_row_buffers.sv
`timescale 1ns/1ps

module conv_row_buffers (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  conv_pkg::pixel_t in_pixel,
    output logic             in_ready,
    input  conv_pkg::row_t   img_rows,
    pix_stream_if.source     col_out
);

    // Three rotating line stores
    conv_pkg::pixel_t row_mem [conv_pkg::NUM_BUFS][conv_pkg::IMG_W];

    logic [1:0]     wr_buf;
    logic [1:0]     prev_buf;
    logic [1:0]     old_buf;
    conv_pkg::col_t col_cnt;
    conv_pkg::row_t row_cnt;
    logic           accept;
    logic           row_end;
    logic           frame_end;
    logic           emit;

    ////////////////////////////////////////////////////////////////////////////
    // Position tracking
    ////////////////////////////////////////////////////////////////////////////

    // Stall input while a column is waiting downstream
    assign in_ready  = !(col_out.valid && !col_out.ready);
    assign accept    = in_valid && in_ready;
    assign row_end   = (col_cnt == conv_pkg::LAST_COL);
    assign frame_end = row_end && (row_cnt == conv_pkg::row_t'(img_rows - 1'b1));

    // Columns only once two older rows are stored
    assign emit      = accept && (row_cnt > conv_pkg::row_t'(1));

    // Buffers holding the previous row and the one before it
    assign prev_buf  = (wr_buf == 2'd0) ? 2'd2 : wr_buf - 2'd1;
    assign old_buf   = (wr_buf == 2'd2) ? 2'd0 : wr_buf + 2'd1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
            wr_buf  <= 2'd0;
        end else if (accept) begin
            if (frame_end) begin
                col_cnt <= '0;
                row_cnt <= '0;
                wr_buf  <= 2'd0;
            end else if (row_end) begin
                col_cnt <= '0;
                row_cnt <= row_cnt + 1'b1;
                wr_buf  <= (wr_buf == 2'd2) ? 2'd0 : wr_buf + 2'd1;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            row_mem[wr_buf][col_cnt] <= in_pixel;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Column output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_out.valid <= 1'b0;
        end else if (!col_out.valid || col_out.ready) begin
            col_out.valid <= emit;
        end
    end

    // Oldest row lands in index 0, the live pixel on top
    always_ff @(posedge clk) begin
        if (emit) begin
            col_out.data <= {in_pixel, row_mem[prev_buf][col_cnt], row_mem[old_buf][col_cnt]};
            col_out.eol  <= row_end;
            col_out.last <= frame_end;
        end
    end

    // A stalled column blocks input and is held into the next cycle
    a_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        col_out.valid && !col_out.ready |->
            !in_ready ##1 (col_out.valid && $stable(col_out.data)))
        else $error("row buffers accepted a pixel or dropped a stalled column");

endmodule

//--- conv_window.sv
`timescale 1ns/1ps

module conv_window (
    input  logic         clk,
    input  logic         rst_n,
    pix_stream_if.sink   col_in,
    pix_stream_if.source win_out
);

    typedef enum logic {
        SHIFT,
        EAST_PAD
    } state_e;

    state_e          state;
    conv_pkg::col3_t prev1;
    conv_pkg::col3_t prev2;
    conv_pkg::col_t  col_idx;
    logic            pend_eol;
    logic            pend_last;
    logic            slot_free;
    logic            accept;

    // Lay three columns out as a row-major 3x3 window
    function automatic conv_pkg::win_t build_win(input conv_pkg::col3_t west,
                                                 input conv_pkg::col3_t centre,
                                                 input conv_pkg::col3_t east);
        conv_pkg::win_t w;
        for (int r = 0; r < conv_pkg::KERN_K; r++) begin
            w[conv_pkg::KERN_K*r]     = west[r];
            w[conv_pkg::KERN_K*r + 1] = centre[r];
            w[conv_pkg::KERN_K*r + 2] = east[r];
        end
        return w;
    endfunction

    assign slot_free    = !win_out.valid || win_out.ready;
    assign col_in.ready = (state == SHIFT) && slot_free;
    assign accept       = col_in.valid && col_in.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= SHIFT;
            col_idx       <= '0;
            win_out.valid <= 1'b0;
        end else begin
            case (state)
                SHIFT: begin
                    // Column 0 only primes the window
                    if (slot_free) begin
                        win_out.valid <= accept && (col_idx != '0);
                    end
                    if (accept) begin
                        if (col_idx == conv_pkg::LAST_COL) begin
                            col_idx <= '0;
                            state   <= EAST_PAD;
                        end else begin
                            col_idx <= col_idx + 1'b1;
                        end
                    end
                end
                EAST_PAD: begin
                    if (slot_free) begin
                        win_out.valid <= 1'b1;
                        state         <= SHIFT;
                    end
                end
                default: state <= SHIFT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            prev1 <= col_in.data;
            prev2 <= prev1;
            if (col_idx == conv_pkg::LAST_COL) begin
                pend_eol  <= col_in.eol;
                pend_last <= col_in.last;
            end
        end
        if (accept) begin
            // West pad when centred on column 0
            win_out.data <= build_win((col_idx == conv_pkg::col_t'(1)) ?
                                      conv_pkg::col3_t'('0) : prev2, prev1, col_in.data);
            win_out.eol  <= 1'b0;
            win_out.last <= 1'b0;
        end else if (state == EAST_PAD && slot_free) begin
            win_out.data <= build_win(prev2, prev1, conv_pkg::col3_t'('0));
            win_out.eol  <= pend_eol;
            win_out.last <= pend_last;
        end
    end

    // The pad window follows the column that closed the row
    a_pad_blocks_input: assert property (@(posedge clk) disable iff (!rst_n)
        state == EAST_PAD |-> !col_in.ready && pend_eol)
        else $error("column accepted or row end missing during east pad window");

    // Row end from the row buffers must line up with the local column count
    a_eol_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        accept && col_in.eol |=> state == EAST_PAD)
        else $error("column eol out of step with window column index");

endmodule

//--- conv_mac.sv
`timescale 1ns/1ps

module conv_mac (
    input  logic              clk,
    input  logic              rst_n,
    input  conv_pkg::kernel_t kernel,
    pix_stream_if.sink        win_in,
    pix_stream_if.source      sum_out
);

    conv_pkg::prod_t prod [conv_pkg::KERN_N];
    logic            s1_valid;
    logic            s1_last;
    logic            s1_eol;
    logic            s1_adv;
    logic            s2_adv;
    conv_pkg::acc_t  prod_sum;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline flow control
    ////////////////////////////////////////////////////////////////////////////

    // Each stage moves when it is empty or the next one takes its item
    assign s2_adv       = !sum_out.valid || sum_out.ready;
    assign s1_adv       = !s1_valid || s2_adv;
    assign win_in.ready = s1_adv;

    ////////////////////////////////////////////////////////////////////////////
    // Stage 1, products
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (s1_adv) begin
            s1_valid <= win_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_adv && win_in.valid) begin
            for (int i = 0; i < conv_pkg::KERN_N; i++) begin
                // Pixel is unsigned, so extend with a zero before the signed multiply
                prod[i] <= $signed({1'b0, win_in.data[i]}) * $signed(kernel[i]);
            end
            s1_last <= win_in.last;
            s1_eol  <= win_in.eol;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2, accumulate
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        prod_sum = '0;
        for (int i = 0; i < conv_pkg::KERN_N; i++) begin
            prod_sum = prod_sum + conv_pkg::acc_t'(prod[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_out.valid <= 1'b0;
        end else if (s2_adv) begin
            sum_out.valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_adv && s1_valid) begin
            sum_out.data <= prod_sum;
            sum_out.last <= s1_last;
            sum_out.eol  <= s1_eol;
        end
    end

    // Two cycles from window to sum when nothing stalls
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        win_in.valid && win_in.ready && sum_out.ready ##1 sum_out.ready |=>
            sum_out.valid)
        else $error("sum did not appear two cycles after its window");

endmodule

//--- conv_result_out.sv
`timescale 1ns/1ps

module conv_result_out (
    input  logic             clk,
    input  logic             rst_n,
    input  conv_pkg::shift_t shift,
    pix_stream_if.sink       sum_in,
    output logic             out_valid,
    input  logic             out_ready,
    output conv_pkg::pixel_t out_pixel,
    output logic             out_last,
    output logic             out_eol
);

    conv_pkg::acc_t   shifted;
    conv_pkg::pixel_t sat_pixel;
    conv_pkg::pixel_t skid_pixel;
    logic             skid_valid;
    logic             skid_last;
    logic             skid_eol;
    logic             push;
    logic             head_free;

    // Scale down, then clamp into pixel range
    assign shifted = $signed(sum_in.data) >>> shift;

    always_comb begin
        if (shifted < 0) begin
            sat_pixel = '0;
        end else if (shifted > conv_pkg::acc_t'(conv_pkg::PIX_MAX)) begin
            sat_pixel = conv_pkg::pixel_t'(conv_pkg::PIX_MAX);
        end else begin
            sat_pixel = conv_pkg::pixel_t'(shifted);
        end
    end

    // Second entry free means a new sum always has a slot
    assign sum_in.ready = !skid_valid;
    assign push         = sum_in.valid && sum_in.ready;
    assign head_free    = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (head_free) begin
            out_valid  <= skid_valid || push;
            skid_valid <= 1'b0;
        end else if (push) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (head_free) begin
            if (skid_valid) begin
                {out_pixel, out_last, out_eol} <= {skid_pixel, skid_last, skid_eol};
            end else if (push) begin
                {out_pixel, out_last, out_eol} <= {sat_pixel, sum_in.last, sum_in.eol};
            end
        end else if (push) begin
            {skid_pixel, skid_last, skid_eol} <= {sat_pixel, sum_in.last, sum_in.eol};
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=>
            out_valid && $stable(out_pixel) && $stable(out_last) && $stable(out_eol))
        else $error("output changed while stalled");

endmodule

//--- conv_datapath.sv
`timescale 1ns/1ps

module conv_datapath (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    output logic              in_ready,
    input  conv_pkg::pixel_t  in_pixel,
    output logic              out_valid,
    input  logic              out_ready,
    output conv_pkg::pixel_t  out_pixel,
    output logic              out_last,
    output logic              out_eol,
    input  conv_pkg::row_t    img_rows,
    input  conv_pkg::kernel_t kernel,
    input  conv_pkg::shift_t  shift
);

    ////////////////////////////////////////////////////////////////////////////
    // Stage links
    ////////////////////////////////////////////////////////////////////////////

    pix_stream_if #(.data_t(conv_pkg::col3_t)) col_link ();
    pix_stream_if #(.data_t(conv_pkg::win_t))  win_link ();
    pix_stream_if #(.data_t(conv_pkg::acc_t))  sum_link ();

    conv_row_buffers u_row_buffers (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_pixel (in_pixel),
        .in_ready (in_ready),
        .img_rows (img_rows),
        .col_out  (col_link.source)
    );

    conv_window u_window (
        .clk     (clk),
        .rst_n   (rst_n),
        .col_in  (col_link.sink),
        .win_out (win_link.source)
    );

    conv_mac u_mac (
        .clk     (clk),
        .rst_n   (rst_n),
        .kernel  (kernel),
        .win_in  (win_link.sink),
        .sum_out (sum_link.source)
    );

    conv_result_out u_result_out (
        .clk       (clk),
        .rst_n     (rst_n),
        .shift     (shift),
        .sum_in    (sum_link.sink),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pixel (out_pixel),
        .out_last  (out_last),
        .out_eol   (out_eol)
    );

endmodule

//--- tb_conv_datapath.sv
`timescale 1ns/1ps

module tb_conv_datapath;

    localparam int MAX_ROWS   = 8;
    localparam int WAIT_LIMIT = 4000;
    localparam int W          = conv_pkg::IMG_W;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    logic              in_ready;
    conv_pkg::pixel_t  in_pixel;
    logic              out_valid;
    logic              out_ready;
    conv_pkg::pixel_t  out_pixel;
    logic              out_last;
    logic              out_eol;
    conv_pkg::row_t    img_rows;
    conv_pkg::kernel_t kernel;
    conv_pkg::shift_t  shift;

    conv_pkg::pixel_t  frame_mem [MAX_ROWS][W];
    conv_pkg::pixel_t  exp_pix [$];
    logic              exp_eol [$];
    logic              exp_last [$];
    int                errors;
    int                results;
    logic              bp_en;
    logic              hold_out;

    conv_datapath u_conv_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pixel  (in_pixel),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pixel (out_pixel),
        .out_last  (out_last),
        .out_eol   (out_eol),
        .img_rows  (img_rows),
        .kernel    (kernel),
        .shift     (shift)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Output sink that stalls at random while back-pressure is on
    always @(posedge clk) begin
        if (hold_out) begin
            out_ready <= 1'b0;
        end else if (bp_en) begin
            out_ready <= 1'($urandom_range(1));
        end else begin
            out_ready <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks and output monitor
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_pixel(input string name, input conv_pkg::pixel_t got,
                               input conv_pkg::pixel_t exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%02h expected 0x%02h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (exp_pix.size() == 0) begin
                $display("An output pixel arrived with no expected result pending at %0t",
                         $time);
                errors++;
            end else begin
                check_pixel("out_pixel", out_pixel, exp_pix.pop_front());
                check_flag("out_eol", out_eol, exp_eol.pop_front());
                check_flag("out_last", out_last, exp_last.pop_front());
                results++;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers and reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic fill_random(input int rows, input int lo, input int hi);
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < W; c++) begin
                frame_mem[r][c] = conv_pkg::pixel_t'(lo + int'($urandom_range(hi - lo)));
            end
        end
    endtask

    function automatic conv_pkg::kernel_t random_kernel(input int lo, input int hi);
        conv_pkg::kernel_t k;
        for (int i = 0; i < conv_pkg::KERN_N; i++) begin
            k[i] = conv_pkg::weight_t'(lo + int'($urandom_range(hi - lo)));
        end
        return k;
    endfunction

    task automatic set_coeffs(input conv_pkg::kernel_t k, input conv_pkg::shift_t sh);
        kernel <= k;
        shift  <= sh;
        @(posedge clk);
    endtask

    // Horizontal zero pad and no vertical pad before shift and clamp
    task automatic build_expected(input int rows);
        int acc;
        int x;
        for (int r = 0; r < rows - 2; r++) begin
            for (int c = 0; c < W; c++) begin
                acc = 0;
                for (int dr = 0; dr < 3; dr++) begin
                    for (int dc = 0; dc < 3; dc++) begin
                        x = c + dc - 1;
                        if (x >= 0 && x < W) begin
                            acc += int'(frame_mem[r + dr][x]) * int'(kernel[3*dr + dc]);
                        end
                    end
                end
                acc = acc >>> shift;
                if (acc < 0) acc = 0;
                if (acc > 255) acc = 255;
                exp_pix.push_back(conv_pkg::pixel_t'(acc));
                exp_eol.push_back(c == W - 1);
                exp_last.push_back(c == W - 1 && r == rows - 3);
            end
        end
    endtask

    task automatic drive_pixels(input int rows, input int count, input int gap_pct);
        int n;
        img_rows <= conv_pkg::row_t'(rows);
        for (int i = 0; i < count; i++) begin
            if (int'($urandom_range(99)) < gap_pct) begin
                in_valid <= 1'b0;
                repeat ($urandom_range(3, 1)) @(posedge clk);
            end
            in_valid <= 1'b1;
            in_pixel <= frame_mem[i / W][i % W];
            @(posedge clk);
            n = 0;
            while (!in_ready && n < WAIT_LIMIT) begin
                @(posedge clk);
                n++;
            end
            if (!in_ready) begin
                $display("Timed out waiting for in_ready on input pixel %0d", i);
                errors++;
                break;
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic wait_drain(input string what);
        int n;
        n = 0;
        while (exp_pix.size() != 0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (exp_pix.size() != 0) begin
            $display("Timed out in %s test with %0d results never produced",
                     what, exp_pix.size());
            errors++;
            exp_pix.delete();
            exp_eol.delete();
            exp_last.delete();
        end
        // Room for any extra result to show up
        repeat (20) @(posedge clk);
    endtask

    task automatic run_frame(input int rows, input int gap_pct, input string what);
        build_expected(rows);
        drive_pixels(rows, rows * W, gap_pct);
        wait_drain(what);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic identity_kernel();
        conv_pkg::kernel_t k;
        k    = '0;
        k[4] = conv_pkg::weight_t'(1);
        fill_random(5, 0, 255);
        set_coeffs(k, '0);
        run_frame(5, 0, "identity");
    endtask

    task automatic horizontal_sum();
        conv_pkg::kernel_t k;
        k = '0;
        for (int i = 3; i < 6; i++) begin
            k[i] = conv_pkg::weight_t'(1);
        end
        // Value depends on row and column
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < W; c++) begin
                frame_mem[r][c] = conv_pkg::pixel_t'(r * W + c);
            end
        end
        set_coeffs(k, '0);
        run_frame(4, 0, "horizontal sum");
    endtask

    task automatic saturation_and_shift();
        fill_random(5, 200, 255);
        set_coeffs(random_kernel(127, 127), '0);
        run_frame(5, 0, "clamp high");
        set_coeffs(random_kernel(-1, -1), '0);
        run_frame(5, 0, "clamp low");
        fill_random(6, 0, 255);
        set_coeffs(random_kernel(-20, 20), conv_pkg::shift_t'(3));
        run_frame(6, 0, "shifted");
    endtask

    task automatic random_backpressure();
        bp_en <= 1'b1;
        fill_random(7, 0, 255);
        set_coeffs(random_kernel(-6, 6), conv_pkg::shift_t'(2));
        run_frame(7, 30, "back-pressure");
        bp_en <= 1'b0;
    endtask

    // Two frames back to back with different row counts
    task automatic back_to_back_frames();
        set_coeffs(random_kernel(-3, 3), conv_pkg::shift_t'(1));
        fill_random(3, 0, 255);
        build_expected(3);
        drive_pixels(3, 3 * W, 0);
        fill_random(6, 0, 255);
        build_expected(6);
        drive_pixels(6, 6 * W, 0);
        wait_drain("framing");
    endtask

    task automatic reset_mid_frame();
        int n;
        hold_out <= 1'b1;
        fill_random(5, 0, 255);
        // Two rows and a few columns whose results stay stuck inside
        drive_pixels(5, 2 * W + 4, 0);
        n = 0;
        while (!out_valid && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!out_valid) begin
            $display("Timed out waiting for a stalled result before the mid-frame reset");
            errors++;
        end
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        check_flag("out_valid", out_valid, 1'b0);
        rst_n    <= 1'b1;
        hold_out <= 1'b0;
        @(posedge clk);
        fill_random(5, 0, 255);
        run_frame(5, 0, "after reset");
    endtask

    initial begin
        void'($urandom(32'h757f));
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_pixel  = '0;
        out_ready = 1'b1;
        img_rows  = conv_pkg::row_t'(5);
        kernel    = '0;
        shift     = '0;
        bp_en     = 1'b0;
        hold_out  = 1'b0;
        errors    = 0;
        results   = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        identity_kernel();
        horizontal_sum();
        saturation_and_shift();
        random_backpressure();
        back_to_back_frames();
        reset_mid_frame();

        $display("Results checked: %0d, errors: %0d", results, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
conv_pkg.sv
pix_stream_if.sv
conv_row_buffers.sv
conv_window.sv
conv_mac.sv
conv_result_out.sv
conv_datapath.sv
tb_conv_datapath.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for failure

verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_datapath \
    -f project.f > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vtb_conv_datapath > sim.log 2>&1 \
    || { echo "Simulation exited with an error, see sim.log"; exit 1; }

grep -q "TEST FAILED" sim.log && { echo "Simulation reported failure, see sim.log"; exit 1; }
grep -q "TEST OK" sim.log || { echo "Simulation ended without a result, see sim.log"; exit 1; }
echo "Simulation passed"
